//--- cpuPkg.sv
package cpuPkg;

  parameter int WordWidth    = 32;  // Data and address width
  parameter int RegAddrWidth = 8;   // One register field of the instruction word

  // Instruction set, low byte of the first word
  typedef enum logic [7:0] {
    Stall  = 8'h00,  // Hold ip, re-fetch forever
    MovRC  = 8'h01,  // rA = const
    MovRR  = 8'h02,  // rA = rB
    MovRdC = 8'h03,  // rA = [const]
    MovRdR = 8'h04,  // rA = [rB]
    MovdCR = 8'h05,  // [const] = rB
    MovdRR = 8'h06,  // [rA] = rB
    PushR  = 8'h07,  // [r0] = rA, r0 += 4
    PopR   = 8'h08,  // rA = [r0 - 4], r0 -= 4
    AddRRC = 8'h10,  // rA = rB + const
    AddRRR = 8'h11,  // rA = rB + rC
    SubRRC = 8'h12,  // rA = rB - const
    SubRRR = 8'h13,  // rA = rB - rC
    CmpRR  = 8'h18,  // flags = rA ? rB
    CmpRC  = 8'h19,  // flags = rA ? const
    JmpC   = 8'h20,  // ip = const
    JeC    = 8'h21,  // ip = const if equal
    JneC   = 8'h22,  // ip = const if not equal
    DoutR  = 8'h30   // Debug port = rA
  } opCodeE;

  // First instruction word, opcode in the low byte
  typedef struct packed {
    logic [RegAddrWidth-1:0] regC;  // High byte
    logic [RegAddrWidth-1:0] regB;
    logic [RegAddrWidth-1:0] regA;
    opCodeE                  opCode;
  } instrFieldsT;

  // Same 32 bits seen as a RAM word or as fields
  typedef union packed {
    logic [WordWidth-1:0] raw;
    instrFieldsT          fields;
  } instrWordU;

  // 8-byte forms, constant word at ip+4
  function automatic logic isTwoWord(opCodeE op);
    return op inside {MovRC, MovRdC, MovdCR, AddRRC, SubRRC, CmpRC, JmpC, JeC, JneC};
  endfunction

  // Loads, including the stack pop
  function automatic logic isMemRead(opCodeE op);
    return op inside {MovRdC, MovRdR, PopR};
  endfunction

  // Stores, including the stack push
  function automatic logic isMemWrite(opCodeE op);
    return op inside {MovdCR, MovdRR, PushR};
  endfunction

endpackage

//--- regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; #(
  parameter int                   NumRegs    = 16,
  parameter logic [WordWidth-1:0] StackReset = 32'h0000_0400
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [RegAddrWidth-1:0] regAddrA,
  input  logic [RegAddrWidth-1:0] regAddrB,
  input  logic [RegAddrWidth-1:0] regAddrC,
  input  logic                    wrEn,
  input  logic [RegAddrWidth-1:0] wrAddr,
  input  logic [WordWidth-1:0]    wrData,
  input  logic                    spInc,     // r0 += 4
  input  logic                    spDec,     // r0 -= 4
  input  logic                    flagWrEn,
  input  logic [2:0]              flagData,  // gt, lt, eq
  output logic [WordWidth-1:0]    regValA,
  output logic [WordWidth-1:0]    regValB,
  output logic [WordWidth-1:0]    regValC,
  output logic [2:0]              flags
);

  localparam int IdxW = $clog2(NumRegs);

  logic [WordWidth-1:0] regs [NumRegs];
  logic [IdxW-1:0]      wrIdx;

  assign wrIdx = wrAddr[IdxW-1:0];

  // Combinational read ports
  assign regValA = regs[regAddrA[IdxW-1:0]];
  assign regValB = regs[regAddrB[IdxW-1:0]];
  assign regValC = regs[regAddrC[IdxW-1:0]];
  assign flags   = regs[1][2:0];  // Flags live in r1

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= (i == 0) ? StackReset : '0;  // r0 is the stack pointer
      end
    end else begin
      for (int i = 0; i < NumRegs; i++) begin
        if (wrEn && wrIdx == IdxW'(i)) begin
          regs[i] <= wrData;                     // Wins over the SP adjust
        end else if (i == 0 && spInc) begin
          regs[i] <= regs[i] + 4;
        end else if (i == 0 && spDec) begin
          regs[i] <= regs[i] - 4;
        end else if (i == 1 && flagWrEn) begin
          regs[i][2:0] <= flagData;              // Upper bits kept
        end
      end
    end
  end

endmodule

//--- execUnit.sv
`timescale 1ns/1ps

module execUnit import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    execute,     // One cycle per instruction
  input  opCodeE                  opCode,
  input  logic [WordWidth-1:0]    dataWord,
  input  logic [WordWidth-1:0]    memValue,
  input  logic [RegAddrWidth-1:0] regAddrA,    // Destination field
  input  logic [WordWidth-1:0]    regValA,
  input  logic [WordWidth-1:0]    regValB,
  input  logic [WordWidth-1:0]    regValC,
  input  logic [2:0]              flags,
  output logic                    wrEn,
  output logic [RegAddrWidth-1:0] wrAddr,
  output logic [WordWidth-1:0]    wrData,
  output logic                    spInc,
  output logic                    spDec,
  output logic                    flagWrEn,
  output logic [2:0]              flagData,
  output logic                    takeJump,
  output logic [WordWidth-1:0]    jumpTarget,
  output logic [WordWidth-1:0]    doutValue,
  output logic                    doutValid
);

  logic [WordWidth-1:0] cmpRhs;   // Right-hand compare operand
  logic                 doutHit;

  assign cmpRhs  = (opCode == CmpRC) ? dataWord : regValB;
  assign doutHit = execute && (opCode == DoutR);

  always_comb begin
    wrEn       = 1'b0;
    wrAddr     = '0;
    wrData     = '0;
    spInc      = 1'b0;
    spDec      = 1'b0;
    flagWrEn   = 1'b0;
    flagData   = '0;
    takeJump   = 1'b0;
    jumpTarget = '0;
    if (execute) begin
      unique case (opCode)
        MovRC: begin
          wrEn   = 1'b1;
          wrAddr = regAddrA;
          wrData = dataWord;
        end
        MovRR: begin
          wrEn   = 1'b1;
          wrAddr = regAddrA;
          wrData = regValB;
        end
        MovRdC, MovRdR: begin
          wrEn   = 1'b1;
          wrAddr = regAddrA;
          wrData = memValue;                // Loaded word
        end
        PushR:  spInc = 1'b1;               // Store already done
        PopR: begin
          wrEn   = 1'b1;
          wrAddr = regAddrA;
          wrData = memValue;                // Popped word
          spDec  = 1'b1;
        end
        AddRRC, AddRRR, SubRRC, SubRRR: begin
          wrEn   = 1'b1;
          wrAddr = regAddrA;
          unique case (opCode)
            AddRRC:  wrData = regValB + dataWord;
            AddRRR:  wrData = regValB + regValC;
            SubRRC:  wrData = regValB - dataWord;
            default: wrData = regValB - regValC;  // Wraps mod 2^32
          endcase
        end
        CmpRR, CmpRC: begin
          flagWrEn = 1'b1;
          flagData = {regValA > cmpRhs,     // gt
                      regValA < cmpRhs,     // lt
                      regValA == cmpRhs};   // eq, unsigned compare
        end
        JmpC: begin
          takeJump   = 1'b1;
          jumpTarget = dataWord;
        end
        JeC: begin
          takeJump   = flags[0];
          jumpTarget = dataWord;
        end
        JneC: begin
          takeJump   = !flags[0];
          jumpTarget = dataWord;
        end
        default: ;                          // Stall, stores, DoutR
      endcase
    end
  end

  // Debug port pulse
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      doutValid <= 1'b0;
    end else begin
      doutValid <= doutHit;
    end
  end

  always_ff @(posedge clk) begin
    if (doutHit) begin
      doutValue <= regValA;   // Held until the next DoutR
    end
  end

endmodule

//--- fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer import cpuPkg::*; #(
  parameter int NumRegs = 16  // Sets how many field bits are kept
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [WordWidth-1:0]    ramIn,
  input  logic [WordWidth-1:0]    regValA,
  input  logic [WordWidth-1:0]    regValB,
  input  logic [WordWidth-1:0]    regValC,     // r0 during PushR and PopR
  input  logic                    takeJump,
  input  logic [WordWidth-1:0]    jumpTarget,
  output logic [WordWidth-1:0]    ramAddress,
  output logic [WordWidth-1:0]    ramOut,
  output logic                    readReq,
  output logic                    writeReq,
  output logic [RegAddrWidth-1:0] regAddrA,
  output logic [RegAddrWidth-1:0] regAddrB,
  output logic [RegAddrWidth-1:0] regAddrC,
  output opCodeE                  opCode,
  output logic [WordWidth-1:0]    dataWord,    // Constant from the 8-byte form
  output logic [WordWidth-1:0]    memValue,    // Loaded word
  output logic                    execute
);

  localparam int IdxW = $clog2(NumRegs);

  // Phase encoding
  localparam logic [3:0] SIdle      = 4'd0;  // Only after reset
  localparam logic [3:0] SFetch     = 4'd1;  // Instruction request at ip
  localparam logic [3:0] SFetchWait = 4'd2;  // Word on ramIn, fields captured
  localparam logic [3:0] SDecode    = 4'd3;  // Register read, pick next phase
  localparam logic [3:0] SDataReq   = 4'd4;  // Request at ip+4
  localparam logic [3:0] SDataCap   = 4'd5;
  localparam logic [3:0] SMemReq    = 4'd6;  // Load or store pulse
  localparam logic [3:0] SMemWait   = 4'd7;
  localparam logic [3:0] SMemCap    = 4'd8;
  localparam logic [3:0] SExec      = 4'd9;

  logic [3:0]              state;
  logic [WordWidth-1:0]    ip;               // Instruction pointer
  logic [RegAddrWidth-1:0] fldA, fldB, fldC; // Raw register fields
  instrWordU               instrWord;
  logic                    stackOp;
  logic                    memOp;
  logic [WordWidth-1:0]    memAddr;
  logic [WordWidth-1:0]    memData;

  assign instrWord.raw = ramIn;  // Decode view of the fetched word

  assign stackOp = (opCode == PushR) || (opCode == PopR);
  assign memOp   = isMemRead(opCode) || isMemWrite(opCode);

  // Low field bits address the file directly
  assign regAddrA = {{(RegAddrWidth - IdxW){1'b0}}, fldA[IdxW-1:0]};
  assign regAddrB = {{(RegAddrWidth - IdxW){1'b0}}, fldB[IdxW-1:0]};
  assign regAddrC = stackOp ? '0                                          // Stack pointer
                            : {{(RegAddrWidth - IdxW){1'b0}}, fldC[IdxW-1:0]};

  // Data-side address
  always_comb begin
    unique case (opCode)
      MovRdC, MovdCR: memAddr = dataWord;
      MovRdR:         memAddr = regValB;
      MovdRR:         memAddr = regValA;
      PushR:          memAddr = regValC;        // Current top of stack
      PopR:           memAddr = regValC - 4;    // Last pushed word
      default:        memAddr = '0;
    endcase
  end

  // Store data
  always_comb begin
    unique case (opCode)
      MovdCR, MovdRR: memData = regValB;
      PushR:          memData = regValA;
      default:        memData = '0;
    endcase
  end

  // One-cycle RAM request levels
  assign readReq  = (state == SFetch) || (state == SDataReq)
                  || (state == SMemReq && isMemRead(opCode));
  assign writeReq = (state == SMemReq) && isMemWrite(opCode);
  assign ramOut   = memData;
  assign execute  = (state == SExec);

  always_comb begin
    unique case (state)
      SDataReq: ramAddress = ip + 4;   // Constant word
      SMemReq:  ramAddress = memAddr;
      default:  ramAddress = ip;       // Instruction fetch
    endcase
  end

  // Phase FSM and ip
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state  <= SIdle;
      ip     <= '0;
      opCode <= Stall;
    end else begin
      unique case (state)
        SIdle:      state <= SFetch;
        SFetch:     state <= SFetchWait;
        SFetchWait: begin
          opCode <= instrWord.fields.opCode;
          state  <= SDecode;
        end
        SDecode: begin
          if (isTwoWord(opCode)) begin
            state <= SDataReq;
          end else if (memOp) begin
            state <= SMemReq;
          end else begin
            state <= SExec;
          end
        end
        SDataReq:   state <= SDataCap;
        SDataCap:   state <= memOp ? SMemReq : SExec;
        SMemReq:    state <= SMemWait;
        SMemWait:   state <= SMemCap;
        SMemCap:    state <= SExec;
        SExec: begin
          if (takeJump) begin
            ip <= jumpTarget;
          end else if (opCode != Stall) begin
            ip <= ip + (isTwoWord(opCode) ? 32'd8 : 32'd4);
          end
          state <= SFetch;  // Next fetch right after execute
        end
        default:    state <= SIdle;
      endcase
    end
  end

  // Instruction payload captures
  always_ff @(posedge clk) begin
    if (state == SFetchWait) begin
      fldA <= instrWord.fields.regA;
      fldB <= instrWord.fields.regB;
      fldC <= instrWord.fields.regC;
    end
    if (state == SDataCap) begin
      dataWord <= ramIn;
    end
    if (state == SMemCap) begin
      memValue <= ramIn;  // Held since the registered read
    end
  end

endmodule

//--- cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
  parameter int                   NumRegs    = 16,            // Power of two, 4 to 64
  parameter logic [WordWidth-1:0] StackReset = 32'h0000_0400  // Initial r0
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [WordWidth-1:0] ramIn,       // Registered RAM read data
  output logic [WordWidth-1:0] ramAddress,
  output logic [WordWidth-1:0] ramOut,
  output logic                 readReq,
  output logic                 writeReq,
  output logic [WordWidth-1:0] doutValue,   // Last DoutR value
  output logic                 doutValid    // One pulse per DoutR
);

  // Register file read side
  logic [RegAddrWidth-1:0] regAddrA, regAddrB, regAddrC;
  logic [WordWidth-1:0]    regValA, regValB, regValC;
  logic [2:0]              flags;

  // Held instruction state
  opCodeE                  opCode;
  logic [WordWidth-1:0]    dataWord, memValue;
  logic                    execute;

  // Write-back
  logic                    wrEn;
  logic [RegAddrWidth-1:0] wrAddr;
  logic [WordWidth-1:0]    wrData;
  logic                    spInc, spDec;
  logic                    flagWrEn;
  logic [2:0]              flagData;

  // Branch back to the sequencer
  logic                    takeJump;
  logic [WordWidth-1:0]    jumpTarget;

  fetchSequencer #(.NumRegs(NumRegs)) u_fetchSequencer (
    .clk, .rstN, .ramIn, .regValA, .regValB, .regValC, .takeJump, .jumpTarget,
    .ramAddress, .ramOut, .readReq, .writeReq, .regAddrA, .regAddrB, .regAddrC,
    .opCode, .dataWord, .memValue, .execute
  );

  regFile #(.NumRegs(NumRegs), .StackReset(StackReset)) u_regFile (
    .clk, .rstN, .regAddrA, .regAddrB, .regAddrC, .wrEn, .wrAddr, .wrData,
    .spInc, .spDec, .flagWrEn, .flagData, .regValA, .regValB, .regValC, .flags
  );

  execUnit u_execUnit (
    .clk, .rstN, .execute, .opCode, .dataWord, .memValue, .regAddrA,
    .regValA, .regValB, .regValC, .flags, .wrEn, .wrAddr, .wrData, .spInc, .spDec,
    .flagWrEn, .flagData, .takeJump, .jumpTarget, .doutValue, .doutValid
  );

endmodule

//--- cpuTbRam.sv
`timescale 1ns/1ps

module cpuTbRam import cpuPkg::*; #(
  parameter int Depth = 1024  // Words, byte addresses 0 to 4*Depth-1
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [WordWidth-1:0] ramAddress,
  input  logic [WordWidth-1:0] ramOut,
  input  logic                 readReq,
  input  logic                 writeReq,
  output logic [WordWidth-1:0] ramIn,
  output logic                 addrError   // Sticky, request outside the array
);

  localparam int IdxW = $clog2(Depth);

  logic [WordWidth-1:0] mem [Depth];  // Loaded and inspected by the testbench
  logic [IdxW-1:0]      idx;
  logic                 inRange;

  assign idx     = ramAddress[IdxW+1:2];
  assign inRange = (ramAddress < WordWidth'(4 * Depth)) && (ramAddress[1:0] == 2'b00);

  initial ramIn = '0;

  always @(posedge clk) begin
    if (writeReq && inRange) begin
      mem[idx] <= ramOut;
    end
    if (readReq) begin
      ramIn <= inRange ? mem[idx] : 'x;  // Held until the next read
    end
  end

  // Stray or unaligned access
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      addrError <= 1'b0;
    end else if ((readReq || writeReq) && !inRange) begin
      addrError <= 1'b1;
    end
  end

endmodule

//--- cpuTb.sv
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

  localparam logic [WordWidth-1:0] StackBase = 32'h0000_0400;
  localparam int RamDepth    = 1024;
  localparam int NumRows     = 14;
  localparam int MaxInstrs   = 9;   // Stack program incl. Stall
  localparam int QuietCycles = 50;  // Watch window after the last output
  localparam int WatchdogCycles = NumRows * (MaxInstrs * 40 + QuietCycles + 8);

  typedef enum int {tAddRr, tSubRr, tAddRc, tSubRc, tCmpJe, tCmpJne,
                    tStoreLoad, tStack, tJumpHalt} testKindE;

  logic                 clk, rstN;
  logic [WordWidth-1:0] ramAddress, ramOut, ramIn, doutValue;
  logic                 readReq, writeReq, doutValid, addrError;

  // Test table
  testKindE             kinds [NumRows];
  logic [WordWidth-1:0] opA [NumRows], opB [NumRows], expVal [NumRows];
  int                   rowCount;

  logic [WordWidth-1:0] prog [$];   // Program image from address 0
  logic [WordWidth-1:0] outs [$];   // doutValue at each doutValid
  logic                 writeSeen;
  logic [31:0]          lfsr = 32'hf5a;

  cpuTop #(.NumRegs(16), .StackReset(StackBase)) u_cpuTop (
    .clk, .rstN, .ramIn, .ramAddress, .ramOut, .readReq, .writeReq, .doutValue, .doutValid
  );

  cpuTbRam #(.Depth(RamDepth)) u_cpuTbRam (
    .clk, .rstN, .ramAddress, .ramOut, .readReq, .writeReq, .ramIn, .addrError
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    failRun("Timeout: a test program never finished");
  end

  // Output and store monitor on the falling edge
  always @(negedge clk) begin
    if (rstN && doutValid) begin
      outs.push_back(doutValue);
    end
    if (rstN && writeReq) begin
      writeSeen = 1'b1;
    end
  end

  task automatic failRun(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic checkWord(string name, logic [WordWidth-1:0] got, logic [WordWidth-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic [WordWidth-1:0] randBits(int n);
    logic [WordWidth-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[WordWidth-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // First debug output each program must produce
  function automatic logic [WordWidth-1:0] firstOut(testKindE k, logic [WordWidth-1:0] a, b);
    case (k)
      tAddRr, tAddRc: return a + b;         // Mod 2^32
      tSubRr, tSubRc: return a - b;
      tCmpJe:         return (a == b) ? 2 : 1;  // Taken jump skips the 1
      tCmpJne:        return (a != b) ? 2 : 1;
      tStack:         return b;             // Last pushed pops first
      default:        return a;
    endcase
  endfunction

  task automatic addRow(testKindE k, logic [WordWidth-1:0] a, logic [WordWidth-1:0] b);
    kinds[rowCount]  = k;
    opA[rowCount]    = a;
    opB[rowCount]    = b;
    expVal[rowCount] = firstOut(k, a, b);
    rowCount++;
  endtask

  function automatic logic [WordWidth-1:0] encode(opCodeE op, int ra, int rb, int rc);
    return {RegAddrWidth'(rc), RegAddrWidth'(rb), RegAddrWidth'(ra), op};
  endfunction

  task automatic put(opCodeE op, int ra, int rb, int rc);
    prog.push_back(encode(op, ra, rb, rc));
  endtask

  task automatic putConst(opCodeE op, int ra, int rb, logic [WordWidth-1:0] c);
    prog.push_back(encode(op, ra, rb, 0));
    prog.push_back(c);  // Constant word at ip+4
  endtask

  task automatic buildProgram(testKindE k, logic [WordWidth-1:0] a, logic [WordWidth-1:0] b);
    prog.delete();
    case (k)
      tAddRr, tSubRr, tAddRc, tSubRc: begin
        putConst(MovRC, 2, 0, a);
        putConst(MovRC, 3, 0, b);
        if (k == tAddRr) put(AddRRR, 4, 2, 3);
        else if (k == tSubRr) put(SubRRR, 4, 2, 3);
        else if (k == tAddRc) putConst(AddRRC, 4, 2, b);
        else putConst(SubRRC, 4, 2, b);
        put(DoutR, 4, 0, 0);
      end
      tCmpJe, tCmpJne: begin
        putConst(MovRC, 2, 0, a);
        putConst(MovRC, 3, 0, b);
        put(CmpRR, 2, 3, 0);
        if (k == tCmpJe) putConst(JeC, 0, 0, 4 * (prog.size() + 5));  // Past 3 words
        else putConst(JneC, 0, 0, 4 * (prog.size() + 5));
        putConst(MovRC, 4, 0, 1);
        put(DoutR, 4, 0, 0);
        putConst(MovRC, 4, 0, 2);  // Jump lands here
        put(DoutR, 4, 0, 0);
      end
      tStoreLoad: begin
        putConst(MovRC, 2, 0, a);
        putConst(MovdCR, 0, 2, b);
        putConst(MovRC, 3, 0, b);
        put(MovRdR, 4, 3, 0);
        put(DoutR, 4, 0, 0);
      end
      tStack: begin
        putConst(MovRC, 2, 0, a);
        putConst(MovRC, 3, 0, b);
        put(PushR, 2, 0, 0);
        put(PushR, 3, 0, 0);
        put(PopR, 4, 0, 0);
        put(PopR, 5, 0, 0);
        put(DoutR, 4, 0, 0);
        put(DoutR, 5, 0, 0);
      end
      default: begin
        putConst(MovRC, 2, 0, b);  // Wrong value
        putConst(MovRC, 3, 0, a);
        putConst(JmpC, 0, 0, 4 * (prog.size() + 3));
        put(DoutR, 2, 0, 0);       // Must be skipped
        put(DoutR, 3, 0, 0);
      end
    endcase
    put(Stall, 0, 0, 0);
  endtask

  task automatic runRow(int r);
    int nOut;
    @(negedge clk);
    rstN = 1'b0;
    buildProgram(kinds[r], opA[r], opB[r]);
    for (int i = 0; i < RamDepth; i++) begin
      u_cpuTbRam.mem[i] = 32'hc3c3_0000 ^ WordWidth'(i << 2);  // Address-keyed fill
    end
    foreach (prog[i]) u_cpuTbRam.mem[i] = prog[i];
    outs.delete();
    writeSeen = 1'b0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    nOut = 1;
    if (kinds[r] == tStack) nOut = 2;
    if ((kinds[r] == tCmpJe || kinds[r] == tCmpJne) && expVal[r] == 1) nOut = 2;
    while (outs.size() < nOut) @(negedge clk);
    repeat (QuietCycles) @(negedge clk);  // Stall must stay silent
    checkWord("doutCount", outs.size(), nOut);
    checkWord("doutValue", outs[0], expVal[r]);
    case (kinds[r])
      tCmpJe, tCmpJne: checkWord("doutValue", outs[outs.size()-1], 2);
      tStoreLoad:      checkWord("ramWord", u_cpuTbRam.mem[opB[r] >> 2], opA[r]);
      tStack: begin
        checkWord("doutValue", outs[1], opA[r]);
        checkWord("ramWord", u_cpuTbRam.mem[StackBase >> 2], opA[r]);
        checkWord("ramWord", u_cpuTbRam.mem[(StackBase >> 2) + 1], opB[r]);
      end
      tJumpHalt:       checkFlag("writeReq", writeSeen, 1'b0);
      default: ;
    endcase
    checkFlag("ramAddrError", addrError, 1'b0);
  endtask

  initial begin
    logic [WordWidth-1:0] a, b;
    rstN      = 1'b0;
    writeSeen = 1'b0;
    rowCount  = 0;
    addRow(tAddRr, 32'hffff_fff0, 32'h0000_0025);  // Carry dropped
    addRow(tSubRr, 32'h5, 32'h7);                  // Wraps below zero
    addRow(tAddRc, 32'h1234_5678, 32'h0101_0101);
    addRow(tSubRc, 32'h8000_0000, 32'h1);
    addRow(tCmpJe, 32'hcafe, 32'hcafe);            // Taken
    addRow(tCmpJe, 32'h3, 32'h4);
    addRow(tCmpJne, 32'h9, 32'h9);                 // Not taken
    addRow(tCmpJne, 32'h0, 32'hffff_ffff);
    addRow(tStoreLoad, 32'hdead_beef, 32'h800);
    addRow(tStack, 32'h1111_1111, 32'h2222_2222);
    addRow(tJumpHalt, 32'h600d, 32'hbad);
    a = randBits(32);
    b = randBits(32);
    addRow(tSubRc, a, b);
    a = randBits(32);
    b = 32'h800 | (randBits(7) << 2);  // Aligned word clear of code and stack
    addRow(tStoreLoad, a, b);
    a = randBits(32);
    b = randBits(32);
    addRow(tStack, a, b);
    for (int r = 0; r < NumRows; r++) runRow(r);
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- sources.f
cpuPkg.sv
regFile.sv
execUnit.sv
fetchSequencer.sv
cpuTop.sv
cpuTbRam.sv
cpuTb.sv
